// ==== Makefile ====
VERILATOR ?= verilator
TOP := tb_dec
FLIST := flist.f
BUILD_DIR := obj_dir
FLAGS := --binary --timing -j 0 --top-module $(TOP)
LOG := sim.log
PASS_MSG := All tests passed

SOURCES := $(shell grep -v '^+' $(FLIST)) verif/dec_model.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "No pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
+incdir+verif
src/dec_pkg.sv
src/dec_regfield.sv
src/dec_imm.sv
src/dec_stage.sv
src/dec_top.sv
verif/tb_dec.sv

// ==== src/dec_imm.sv ====
// Immediate extractor and extender, instanced in the top level beside the register field decoder
module dec_imm #(
	parameter int XLEN = 64
) (
	input dec_pkg::fetch_t fetch,
	output logic [XLEN-1:0] imm
);

	logic [dec_pkg::IR_W-1:0] word;
	dec_pkg::opcode_e opcode;
	dec_pkg::func_e func;

	assign word = fetch.ir;
	assign opcode = dec_pkg::opcode_e'(fetch.ir.r2.opcode);
	assign func = dec_pkg::func_e'(fetch.ir.r2.func);

	// ========================================================================
	// Immediate selection
	// ========================================================================

	always_comb begin
		imm = '0;

		case (opcode)
			// Shift amounts reuse the Rb slot as an unsigned count
			dec_pkg::R2: begin
				case (func)
					dec_pkg::SLLI,
					dec_pkg::SRLI: begin
						imm = {{(XLEN-6){1'b0}}, fetch.ir.r2.Rb};
					end
					default: begin
						imm = '0;
					end
				endcase
			end

			// Arithmetic and signed compare take a signed 16 bit constant
			dec_pkg::ADDI,
			dec_pkg::SUBFI,
			dec_pkg::SLTI: begin
				imm = {{(XLEN-16){word[39]}}, word[39:24]};
			end

			// ANDI fills with ones so the upper bits of the source survive
			dec_pkg::ANDI: begin
				imm = {{(XLEN-16){1'b1}}, word[39:24]};
			end

			dec_pkg::ORI,
			dec_pkg::XORI,
			dec_pkg::SLTUI: begin
				imm = {{(XLEN-16){1'b0}}, word[39:24]};
			end

			dec_pkg::BEQ,
			dec_pkg::BNE,
			dec_pkg::BLT,
			dec_pkg::BGE,
			dec_pkg::BLTU,
			dec_pkg::BGEU: begin
				imm = {{(XLEN-14){word[39]}}, word[39:32], word[15:10]};
			end

			// Everything above the link register field is displacement
			dec_pkg::JAL: begin
				imm = {{(XLEN-30){word[39]}}, word[39:10]};
			end

			dec_pkg::LDx: begin
				imm = {{(XLEN-12){fetch.ir.ld.disp[11]}}, fetch.ir.ld.disp};
			end

			dec_pkg::STx: begin
				imm = {{(XLEN-12){fetch.ir.st.disphi[3]}},
					fetch.ir.st.disphi, fetch.ir.st.displo};
			end

			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

// ==== src/dec_pkg.sv ====
// Instruction formats, opcode tables and decode result types shared by the decode stage RTL and testbench
package dec_pkg;

	// ========================================================================
	// Widths
	// ========================================================================

	localparam int IR_W = 40;
	localparam int REG_W = 6;

	// ========================================================================
	// Opcode and function tables
	// ========================================================================

	typedef enum logic [7:0] {
		NOP   = 8'h00,
		BRK   = 8'h01,
		R2    = 8'h02,
		ADDI  = 8'h04,
		SUBFI = 8'h05,
		ANDI  = 8'h08,
		ORI   = 8'h09,
		XORI  = 8'h0A,
		SLTI  = 8'h0C,
		SLTUI = 8'h0D,
		JAL   = 8'h20,
		BEQ   = 8'h28,
		BNE   = 8'h29,
		BLT   = 8'h2A,
		BGE   = 8'h2B,
		BLTU  = 8'h2C,
		BGEU  = 8'h2D,
		LDx   = 8'h60,
		STx   = 8'h68
	} opcode_e;

	// Function codes live in the top byte of an R2 word
	typedef enum logic [7:0] {
		ADD  = 8'h00,
		SUB  = 8'h01,
		AND  = 8'h02,
		OR   = 8'h03,
		XOR  = 8'h04,
		SLL  = 8'h08,
		SRL  = 8'h09,
		SLLI = 8'h0A,
		SRLI = 8'h0B
	} func_e;

	// ========================================================================
	// Instruction formats
	// ========================================================================

	// Each register slot is eight bits: a two bit type above a six bit number
	typedef struct packed {
		logic [7:0] func;
		logic [1:0] Tb;
		logic [5:0] Rb;
		logic [1:0] Ta;
		logic [5:0] Ra;
		logic [1:0] Tt;
		logic [5:0] Rt;
		logic [7:0] opcode;
	} r2_fmt_t;

	typedef struct packed {
		logic [11:0] disp;
		logic [3:0] spare;
		logic [7:0] Ra;
		logic [7:0] Rt;
		logic [7:0] opcode;
	} ld_fmt_t;

	// The store displacement is split around the source register slots
	typedef struct packed {
		logic [3:0] spare;
		logic [3:0] disphi;
		logic [7:0] Rs;
		logic [7:0] Ra;
		logic [7:0] displo;
		logic [7:0] opcode;
	} st_fmt_t;

	typedef union packed {
		r2_fmt_t r2;
		ld_fmt_t ld;
		st_fmt_t st;
	} instr_u;

	// ========================================================================
	// Stage interfaces
	// ========================================================================

	typedef struct packed {
		instr_u ir;
		logic predict_taken;
	} fetch_t;

	typedef struct packed {
		logic [REG_W-1:0] Ra;
		logic [REG_W-1:0] Rb;
		logic [REG_W-1:0] Rt;
		logic rfwr;
		logic branch;
		logic mem_op;
		logic ui;
		logic predict_taken;
	} regdec_t;

endpackage

// ==== src/dec_regfield.sv ====
// Register field and class flag decoder, instanced in the top level beside the immediate decoder
module dec_regfield (
	input dec_pkg::fetch_t fetch,
	output dec_pkg::regdec_t regdec
);

	dec_pkg::opcode_e opcode;
	dec_pkg::func_e func;

	assign opcode = dec_pkg::opcode_e'(fetch.ir.r2.opcode);
	assign func = dec_pkg::func_e'(fetch.ir.r2.func);

	// ========================================================================
	// Field extraction and classification
	// ========================================================================

	always_comb begin
		// Register numbers come straight from the R2 slots unless overridden
		regdec = '0;
		regdec.Ra = fetch.ir.r2.Ra;
		regdec.Rb = fetch.ir.r2.Rb;
		regdec.Rt = fetch.ir.r2.Rt;
		regdec.predict_taken = fetch.predict_taken;
		regdec.ui = 1'b1;

		case (opcode)
			dec_pkg::NOP,
			dec_pkg::BRK: begin
				regdec.ui = 1'b0;
			end

			dec_pkg::R2: begin
				case (func)
					dec_pkg::ADD,
					dec_pkg::SUB,
					dec_pkg::AND,
					dec_pkg::OR,
					dec_pkg::XOR,
					dec_pkg::SLL,
					dec_pkg::SRL,
					dec_pkg::SLLI,
					dec_pkg::SRLI: begin
						regdec.rfwr = 1'b1;
						regdec.ui = 1'b0;
					end
					// Unknown functions stay flagged and write nothing
					default: begin
						regdec.ui = 1'b1;
					end
				endcase
			end

			dec_pkg::ADDI,
			dec_pkg::SUBFI,
			dec_pkg::ANDI,
			dec_pkg::ORI,
			dec_pkg::XORI,
			dec_pkg::SLTI,
			dec_pkg::SLTUI: begin
				regdec.rfwr = 1'b1;
				regdec.ui = 1'b0;
			end

			dec_pkg::LDx: begin
				regdec.rfwr = 1'b1;
				regdec.mem_op = 1'b1;
				regdec.ui = 1'b0;
			end

			// A store has no destination, its Rt slot holds displacement bits
			dec_pkg::STx: begin
				regdec.Rt = '0;
				regdec.mem_op = 1'b1;
				regdec.ui = 1'b0;
			end

			dec_pkg::BEQ,
			dec_pkg::BNE,
			dec_pkg::BLT,
			dec_pkg::BGE,
			dec_pkg::BLTU,
			dec_pkg::BGEU: begin
				regdec.branch = 1'b1;
				regdec.ui = 1'b0;
			end

			// Link register is one of four, the rest of the word is displacement
			dec_pkg::JAL: begin
				regdec.Rt = {4'd0, fetch.ir.r2.Rt[1:0]};
				regdec.rfwr = 1'b1;
				regdec.ui = 1'b0;
			end

			default: begin
				regdec.ui = 1'b1;
			end
		endcase
	end

endmodule

// ==== src/dec_stage.sv ====
// Decode stage boundary that forms the branch target and holds one result under valid/ready flow
module dec_stage #(
	parameter int XLEN = 64
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input dec_pkg::regdec_t regdec,
	input logic [XLEN-1:0] imm,
	input logic [XLEN-1:0] ip,
	output logic out_valid,
	input logic out_ready,
	output dec_pkg::regdec_t out_dec,
	output logic [XLEN-1:0] out_imm,
	output logic [XLEN-1:0] out_target
);

	logic [XLEN-1:0] target;
	logic load;

	// Target wraps at XLEN, the carry out is dropped
	assign target = ip + imm;

	// ========================================================================
	// Handshake
	// ========================================================================

	// The register can take a word when it is empty or being drained this cycle
	assign in_ready = ~out_valid | out_ready;
	assign load = in_valid & in_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	// ========================================================================
	// Result register
	// ========================================================================

	// Payload only moves on an accepted word so back-pressure holds it steady
	always_ff @(posedge clk) begin
		if (load) begin
			out_dec <= regdec;
			out_imm <= imm;
			out_target <= target;
		end
	end

endmodule

// ==== src/dec_top.sv ====
// Decode stage top level that sets XLEN and connects both decoders to the output register
module dec_top #(
	parameter int XLEN = 64
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input dec_pkg::fetch_t in,
	input logic [XLEN-1:0] in_ip,
	output logic out_valid,
	input logic out_ready,
	output dec_pkg::regdec_t out_dec,
	output logic [XLEN-1:0] out_imm,
	output logic [XLEN-1:0] out_target
);

	dec_pkg::regdec_t regdec;
	logic [XLEN-1:0] imm;

	// Both decoders look at the same fetched word in the same cycle
	dec_regfield i_regfield (
		.fetch(in),
		.regdec(regdec)
	);

	dec_imm #(.XLEN(XLEN)) i_imm (
		.fetch(in),
		.imm(imm)
	);

	dec_stage #(.XLEN(XLEN)) i_stage (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.regdec(regdec),
		.imm(imm),
		.ip(in_ip),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_dec(out_dec),
		.out_imm(out_imm),
		.out_target(out_target)
	);

endmodule

// ==== verif/dec_model.svh ====
// Reference decode model and seeded random word generator, included into the decode testbench
`ifndef DEC_MODEL_SVH
`define DEC_MODEL_SVH

// Entry k of each kept opcode and R2 function table sits at bits [8k+7:8k]
localparam logic [151:0] KEPT_OPS = {
	8'h68, 8'h60, 8'h2d, 8'h2c, 8'h2b, 8'h2a, 8'h29, 8'h28, 8'h20,
	8'h0d, 8'h0c, 8'h0a, 8'h09, 8'h08, 8'h05, 8'h04, 8'h02, 8'h01, 8'h00
};
localparam logic [71:0] KEPT_FUNCS = {
	8'h0b, 8'h0a, 8'h09, 8'h08, 8'h04, 8'h03, 8'h02, 8'h01, 8'h00
};

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// Sign extends the low bits of val to the full width
function automatic logic [XLEN-1:0] sext(logic [XLEN-1:0] val, int bits);
	logic signed [XLEN-1:0] v;
	v = val << (XLEN - bits);
	return v >>> (XLEN - bits);
endfunction

function automatic dec_pkg::fetch_t gen_fetch();
	dec_pkg::fetch_t f;
	logic [39:0] w;
	logic [31:0] r;
	logic [31:0] s;
	r = lcg_next();
	s = lcg_next();
	w[39:8] = lcg_next();
	// About one word in eight carries a raw byte that may match no kept opcode
	if (r[31:29] != 3'b000) begin
		w[7:0] = 8'(KEPT_OPS >> (8 * (r[28:8] % 19)));
	end else begin
		w[7:0] = r[23:16];
	end
	if (w[7:0] == 8'h02 && s[31:29] != 3'b000) begin
		w[39:32] = 8'(KEPT_FUNCS >> (8 * (s[28:8] % 9)));
	end
	f.ir = w;
	f.predict_taken = s[7];
	return f;
endfunction

// ============================================================================
// Expected decode
// ============================================================================

function automatic dec_pkg::regdec_t model_regdec(dec_pkg::fetch_t f);
	dec_pkg::regdec_t r;
	logic [39:0] w;
	w = f.ir;
	r = '0;
	r.Ra = w[21:16];
	r.Rb = w[29:24];
	r.Rt = w[13:8];
	r.predict_taken = f.predict_taken;
	case (w[7:0])
		8'h00, 8'h01: r.ui = 1'b0;
		8'h02: begin
			r.ui = !(w[39:32] inside {[8'h00:8'h04], [8'h08:8'h0b]});
			r.rfwr = !r.ui;
		end
		8'h04, 8'h05, 8'h08, 8'h09, 8'h0a, 8'h0c, 8'h0d: r.rfwr = 1'b1;
		8'h20: begin
			r.rfwr = 1'b1;
			r.Rt = {4'd0, w[9:8]};
		end
		8'h28, 8'h29, 8'h2a, 8'h2b, 8'h2c, 8'h2d: r.branch = 1'b1;
		8'h60: begin
			r.rfwr = 1'b1;
			r.mem_op = 1'b1;
		end
		8'h68: begin
			r.Rt = '0;
			r.mem_op = 1'b1;
		end
		default: r.ui = 1'b1;
	endcase
	return r;
endfunction

function automatic logic [XLEN-1:0] model_imm(dec_pkg::fetch_t f);
	logic [39:0] w;
	w = f.ir;
	case (w[7:0])
		8'h02: return (w[39:32] inside {8'h0a, 8'h0b}) ? XLEN'(w[29:24]) : '0;
		8'h04, 8'h05, 8'h0c: return sext(XLEN'(w[39:24]), 16);
		8'h08: return {{(XLEN-16){1'b1}}, w[39:24]};
		8'h09, 8'h0a, 8'h0d: return XLEN'(w[39:24]);
		8'h28, 8'h29, 8'h2a, 8'h2b, 8'h2c, 8'h2d: return sext(XLEN'({w[39:32], w[15:10]}), 14);
		8'h20: return sext(XLEN'(w[39:10]), 30);
		8'h60: return sext(XLEN'(w[39:28]), 12);
		8'h68: return sext(XLEN'({w[35:32], w[15:8]}), 12);
		default: return '0;
	endcase
endfunction

`endif

// ==== verif/tb_dec.sv ====
// Self-checking testbench for the decode stage, with seeded random words under random back-pressure
module tb_dec;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int XLEN = 64;
	localparam int N_WORDS = 2000;
	localparam int BATCH = 250;
	localparam int N_TESTS = N_WORDS / BATCH + 2;
	localparam int CYCLE_LIMIT = 4 * N_WORDS + 100;

	typedef struct packed {
		dec_pkg::regdec_t dec;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] target;
	} expect_t;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_ready;
	dec_pkg::fetch_t in_word;
	logic [XLEN-1:0] in_ip;
	logic out_valid;
	logic out_ready;
	dec_pkg::regdec_t out_dec;
	logic [XLEN-1:0] out_imm;
	logic [XLEN-1:0] out_target;

	logic [31:0] lcg_state;
	logic running = 1'b0;
	logic took = 1'b0;
	logic reset_done = 1'b0;
	expect_t exp_q[$];
	int words_in = 0;
	int words_out = 0;
	int errors = 0;
	int batch_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;

	`include "dec_model.svh"

	dec_top #(.XLEN(XLEN)) i_dut (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in(in_word),
		.in_ip(in_ip),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_dec(out_dec),
		.out_imm(out_imm),
		.out_target(out_target)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================================================
	// Compare tasks and test bookkeeping
	// ========================================================================

	task automatic check_regdec(string name, dec_pkg::regdec_t expected,
			dec_pkg::regdec_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h actual %h", name, expected, actual);
			errors++;
			batch_errors++;
		end
	endtask

	task automatic check_xlen(string name, logic [XLEN-1:0] expected, logic [XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h actual %h", name, expected, actual);
			errors++;
			batch_errors++;
		end
	endtask

	task automatic compare_flag(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %b actual %b", name, expected, actual);
			errors++;
			batch_errors++;
		end
	endtask

	task automatic close_test(string name);
		tests_run++;
		if (batch_errors == 0) begin
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s with %0d errors", name, batch_errors);
		end
		batch_errors = 0;
	endtask

	// ========================================================================
	// Monitor that queues expected results on input transfers and checks output transfers
	// ========================================================================

	always @(posedge clk) begin : monitor
		expect_t e;
		string name;
		if (running) begin
			cycles++;
			if (cycles > CYCLE_LIMIT) begin
				$display("Timeout: the run stalled after %0d cycles with %0d of %0d words out",
					CYCLE_LIMIT, words_out, N_WORDS);
				$display("Some tests failed");
				$finish;
			end else begin
				if (!reset_done) begin
					compare_flag("reset out_valid", 1'b0, out_valid);
					close_test("reset");
					reset_done = 1'b1;
				end
				// A word may only be refused while an undelivered result is held
				compare_flag($sformatf("cycle %0d in_ready", cycles),
					(out_valid && !out_ready) ? 1'b0 : 1'b1, in_ready);
				if (out_valid && out_ready) begin
					if (exp_q.size() == 0) begin
						$display("An output transfer arrived with no accepted word waiting");
						errors++;
						batch_errors++;
					end else begin
						e = exp_q.pop_front();
						words_out++;
						name = $sformatf("word %0d", words_out);
						check_regdec({name, " dec"}, e.dec, out_dec);
						check_xlen({name, " imm"}, e.imm, out_imm);
						check_xlen({name, " target"}, e.target, out_target);
						if (words_out % BATCH == 0) begin
							close_test($sformatf("random batch %0d", words_out / BATCH));
						end
					end
				end
				took = in_valid && in_ready;
				if (took) begin
					e.dec = model_regdec(in_word);
					e.imm = model_imm(in_word);
					e.target = in_ip + e.imm;
					exp_q.push_back(e);
					words_in++;
				end
			end
		end
	end

	// ========================================================================
	// Stimulus on the falling edge
	// ========================================================================

	initial begin : stimulus
		logic [31:0] r;
		lcg_state = 32'hcf49_2cbb;
		rst = 1'b1;
		in_valid = 1'b0;
		in_word = '0;
		in_ip = '0;
		out_ready = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		running = 1'b1;
		while (words_out < N_WORDS) begin
			if (words_in >= N_WORDS) begin
				in_valid = 1'b0;
			end else if (took || !in_valid) begin
				// A stalled offer is held until the stage takes it
				r = lcg_next();
				in_valid = r[31:30] != 2'b00;
				in_word = gen_fetch();
				in_ip = {lcg_next(), lcg_next()};
			end
			r = lcg_next();
			out_ready = (r[31:16] % 3) != 0;
			@(negedge clk);
		end
		// With no more input and the output drained, the stage must fall idle
		in_valid = 1'b0;
		out_ready = 1'b1;
		repeat (4) @(negedge clk);
		compare_flag("drain out_valid", 1'b0, out_valid);
		close_test("drain");
		$display("Summary: %0d of %0d tests passed, %0d failed, %0d errors, %0d words checked",
			tests_run - tests_failed, N_TESTS, tests_failed, errors, words_out);
		if (errors == 0 && tests_failed == 0 && tests_run == N_TESTS) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
